//--- include/fb_consts.svh
// geometry constants for the scanned LED framebuffer
// panel size, subpanel split and bytes per pixel
// derived lane count and address and data widths
`ifndef FB_CONSTS_SVH
`define FB_CONSTS_SVH

// columns across the panel
`define FB_PIXEL_WIDTH 64
// total rows over both subpanels
`define FB_PIXEL_HEIGHT 32
// rows in one subpanel
`define FB_PIXEL_HALFHEIGHT 16
// colour bytes stored for each pixel
`define FB_BYTES_PER_PIXEL 4

// one bit picks the upper or lower subpanel
`define FB_SUBPANEL_BITS ($clog2(`FB_PIXEL_HEIGHT / `FB_PIXEL_HALFHEIGHT))
// selects one byte of the pixel
`define FB_COLOR_BITS ($clog2(`FB_BYTES_PER_PIXEL))
// one lane per subpanel and colour byte pair
`define FB_LANES (1 << (`FB_SUBPANEL_BITS + `FB_COLOR_BITS))

// pixel index inside a subpanel, row * 64 + column
`define FB_PIXEL_BITS ($clog2(`FB_PIXEL_WIDTH * `FB_PIXEL_HALFHEIGHT))
// a single lane stores bytes
`define FB_DATA_BITS 8
// all lanes read side by side
`define FB_WORD_BITS (`FB_LANES * `FB_DATA_BITS)

`endif

//--- logic/fb_types_pkg.sv
// storage side types of the framebuffer
// host write address and write request structs
// lane word holding one byte from every lane
`include "fb_consts.svh"

package fb_types_pkg;

    // host byte address
    // subpanel on top and colour byte at the bottom, pixel in between
    typedef struct packed {
        logic [`FB_SUBPANEL_BITS-1:0] subpanel;
        logic [`FB_PIXEL_BITS-1:0]    pixel;
        logic [`FB_COLOR_BITS-1:0]    color;
    } fb_wr_addr_t;

    // host write strobe
    // a byte goes in on every cycle with we high
    typedef struct packed {
        logic                       we;
        fb_wr_addr_t                addr;
        logic [`FB_DATA_BITS-1:0]   data;
    } fb_wr_req_t;

    // all lanes at one pixel address
    // lane k is byte k, lane index is subpanel * 4 + color
    typedef logic [`FB_LANES-1:0][`FB_DATA_BITS-1:0] fb_lane_word_t;

endpackage

//--- logic/scan_types_pkg.sv
// scan side types of the framebuffer
// scan FSM state encoding and the beat struct

`include "fb_consts.svh"

package scan_types_pkg;

    // scan controller states
    // idle waits for start, run issues reads, drain empties the pipe
    typedef enum logic [1:0] {
        SCAN_IDLE  = 2'd0,
        SCAN_RUN   = 2'd1,
        SCAN_DRAIN = 2'd2
    } scan_state_e;

    // one output beat per pixel position
    // pixel index within the subpanel and the word from all lanes
    typedef struct packed {
        logic [`FB_PIXEL_BITS-1:0]   pixel;
        fb_types_pkg::fb_lane_word_t word;
    } scan_beat_t;

endpackage

//--- logic/mem_lane.sv
// single byte lane of the framebuffer
// simple dual-port RAM with synchronous write
// and a two stage registered read
`timescale 1ns/1ps
`include "fb_consts.svh"

module mem_lane #(
    parameter int ADDR_BITS = `FB_PIXEL_BITS,
    parameter int DW        = `FB_DATA_BITS
) (
    input  logic                 ClockA,
    input  logic                 rst_n,
    input  logic                 we,
    input  logic [ADDR_BITS-1:0] waddr,
    input  logic [DW-1:0]        wdata,
    input  logic                 ren,
    input  logic [ADDR_BITS-1:0] raddr,
    output logic [DW-1:0]        rdata
);
    localparam int DEPTH = 1 << ADDR_BITS;

    // storage array, no reset so it maps onto block RAM
    logic [DW-1:0] mem [DEPTH];
    // first read stage
    logic [ADDR_BITS-1:0] raddr_q;
    logic                 ren_q;

    // write port
    always_ff @(posedge ClockA) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read address captured only on a read
    always_ff @(posedge ClockA) begin
        if (ren) begin
            raddr_q <= raddr;
        end
    end

    // output register holds while no read is pending
    always_ff @(posedge ClockA or negedge rst_n) begin
        if (!rst_n) begin
            ren_q <= 1'b0;
            rdata <= '0;
        end else begin
            ren_q <= ren;
            if (ren_q) begin
                rdata <= mem[raddr_q];
            end
        end
    end

endmodule

//--- logic/multimem.sv
// banked framebuffer RAM
// host byte writes steered to one lane by subpanel and colour
// registered write stage per lane to keep the fan-out short
// parallel read of all lanes at one pixel address
`timescale 1ns/1ps
`include "fb_consts.svh"

module multimem (
    input  logic                        ClockA,
    input  logic                        rst_n,
    input  fb_types_pkg::fb_wr_req_t    wr,
    input  logic                        rd_en,
    input  logic [`FB_PIXEL_BITS-1:0]   rd_addr,
    output fb_types_pkg::fb_lane_word_t rd_word
);
    localparam int LANE_BITS = `FB_SUBPANEL_BITS + `FB_COLOR_BITS;

    // lane picked by the incoming write
    // subpanel gives the upper bit, colour byte the lower ones
    logic [LANE_BITS-1:0] wr_lane;

    assign wr_lane = {wr.addr.subpanel, wr.addr.color};

    genvar k;
    generate
        for (k = 0; k < `FB_LANES; k++) begin : g_lane
            localparam logic [LANE_BITS-1:0] LANE_ID = LANE_BITS'(k);

            // decoded strobe for this lane
            logic                       we_lane;
            // registered write stage
            logic                       we_q;
            logic [`FB_PIXEL_BITS-1:0]  waddr_q;
            logic [`FB_DATA_BITS-1:0]   wdata_q;

            assign we_lane = wr.we && (wr_lane == LANE_ID);

            // enable is control state and clears on reset
            always_ff @(posedge ClockA or negedge rst_n) begin
                if (!rst_n) begin
                    we_q <= 1'b0;
                end else begin
                    we_q <= we_lane;
                end
            end

            // address and data ride along with the enable
            always_ff @(posedge ClockA) begin
                waddr_q <= wr.addr.pixel;
                wdata_q <= wr.data;
            end

            // RAM for this lane
            // all lanes share the read address
            mem_lane #(
                .ADDR_BITS (`FB_PIXEL_BITS),
                .DW        (`FB_DATA_BITS)
            ) u_lane (
                .ClockA (ClockA),
                .rst_n  (rst_n),
                .we     (we_q),
                .waddr  (waddr_q),
                .wdata  (wdata_q),
                .ren    (rd_en),
                .raddr  (rd_addr),
                .rdata  (rd_word[k])
            );
        end
    endgenerate

endmodule

//--- logic/scan_ctrl.sv
// scan controller for the framebuffer
// FSM walking pixel addresses 0 to 1023 once per frame
// valid and pixel shift register matching the RAM read latency
// beat output register and frame done pulse
`timescale 1ns/1ps
`include "fb_consts.svh"

module scan_ctrl (
    input  logic                        ClockA,
    input  logic                        rst_n,
    input  logic                        scan_start,
    output logic                        rd_en,
    output logic [`FB_PIXEL_BITS-1:0]   rd_addr,
    input  fb_types_pkg::fb_lane_word_t rd_word,
    output logic                        beat_valid,
    output scan_types_pkg::scan_beat_t  beat,
    output logic                        scan_busy,
    output logic                        frame_done
);
    // last pixel index of a subpanel
    localparam logic [`FB_PIXEL_BITS-1:0] LAST_PIXEL =
        `FB_PIXEL_BITS'(`FB_PIXEL_WIDTH * `FB_PIXEL_HALFHEIGHT - 1);

    scan_types_pkg::scan_state_e state;
    // next pixel address to read
    logic [`FB_PIXEL_BITS-1:0] addr_cnt;
    // reads in flight, stage 0 is the newest
    logic [1:0]                            vld_sr;
    logic [1:0][`FB_PIXEL_BITS-1:0]        pix_sr;
    // last beat of the frame is on the output
    logic                                  last_beat;

    // one read per cycle while running
    assign rd_en     = (state == scan_types_pkg::SCAN_RUN);
    assign rd_addr   = addr_cnt;
    assign scan_busy = (state != scan_types_pkg::SCAN_IDLE);
    assign last_beat = beat_valid && (beat.pixel == LAST_PIXEL);

    // state machine and address counter
    always_ff @(posedge ClockA or negedge rst_n) begin
        if (!rst_n) begin
            state      <= scan_types_pkg::SCAN_IDLE;
            addr_cnt   <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            case (state)
                scan_types_pkg::SCAN_IDLE: begin
                    // start only counts here, later pulses are dropped
                    if (scan_start) begin
                        state    <= scan_types_pkg::SCAN_RUN;
                        addr_cnt <= '0;
                    end
                end
                scan_types_pkg::SCAN_RUN: begin
                    addr_cnt <= addr_cnt + 1'b1;
                    if (addr_cnt == LAST_PIXEL) begin
                        state <= scan_types_pkg::SCAN_DRAIN;
                    end
                end
                scan_types_pkg::SCAN_DRAIN: begin
                    // wait until pixel 1023 leaves on the beat output
                    if (last_beat) begin
                        state      <= scan_types_pkg::SCAN_IDLE;
                        frame_done <= 1'b1;
                    end
                end
                default: begin
                    state <= scan_types_pkg::SCAN_IDLE;
                end
            endcase
        end
    end

    // valid bits track the two RAM stages, then the beat register
    always_ff @(posedge ClockA or negedge rst_n) begin
        if (!rst_n) begin
            vld_sr     <= '0;
            beat_valid <= 1'b0;
        end else begin
            vld_sr     <= {vld_sr[0], rd_en};
            beat_valid <= vld_sr[1];
        end
    end

    // pixel index follows its read through the pipe
    always_ff @(posedge ClockA) begin
        pix_sr <= {pix_sr[0], rd_addr};
        // rd_word is ready as the pixel reaches stage 1
        if (vld_sr[1]) begin
            beat.pixel <= pix_sr[1];
            beat.word  <= rd_word;
        end
    end

endmodule

//--- logic/framebuffer_top.sv
// top level of the LED framebuffer
// banked lane RAM plus the scan controller
// no registers of its own, latency is that of the scan controller
`timescale 1ns/1ps

module framebuffer_top (
    input  logic                       ClockA,
    input  logic                       rst_n,
    input  fb_types_pkg::fb_wr_req_t   wr,
    input  logic                       scan_start,
    output logic                       beat_valid,
    output scan_types_pkg::scan_beat_t beat,
    output logic                       scan_busy,
    output logic                       frame_done
);
    // read port between scan controller and RAM
    logic                               rd_en;
    logic [$bits(beat.pixel)-1:0]       rd_addr;
    fb_types_pkg::fb_lane_word_t        rd_word;

    // host writes go straight into the banked RAM
    multimem u_mem (
        .ClockA  (ClockA),
        .rst_n   (rst_n),
        .wr      (wr),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_word (rd_word)
    );

    // scan walks the pixels and forms the beats
    scan_ctrl u_scan (
        .ClockA     (ClockA),
        .rst_n      (rst_n),
        .scan_start (scan_start),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_word    (rd_word),
        .beat_valid (beat_valid),
        .beat       (beat),
        .scan_busy  (scan_busy),
        .frame_done (frame_done)
    );

endmodule

//--- tb/fb_asserts.sv
// concurrent checks bound into the scan controller
// read to beat timing, frame done shape, reads only after a start
`timescale 1ns/1ps
`include "fb_consts.svh"

module fb_asserts (
    input logic                        ClockA,
    input logic                        rst_n,
    input logic                        scan_start,
    input logic                        rd_en,
    input logic                        beat_valid,
    input logic [`FB_PIXEL_BITS-1:0]   beat_pixel,
    input logic                        frame_done,
    input scan_types_pkg::scan_state_e state
);
    // last pixel of a subpanel
    localparam logic [`FB_PIXEL_BITS-1:0] LAST_PIXEL =
        `FB_PIXEL_BITS'(`FB_PIXEL_WIDTH * `FB_PIXEL_HALFHEIGHT - 1);

    // assertion failures seen so far
    int failures = 0;

    // two RAM stages, then the beat register
    a_beat_follows_read: assert property (
        @(posedge ClockA) disable iff (!rst_n) beat_valid == $past(rd_en, 3)
    ) else begin
        $error("beat_valid does not track rd_en through the read pipeline");
        failures++;
    end

    // done is a single cycle pulse
    a_done_one_cycle: assert property (
        @(posedge ClockA) disable iff (!rst_n) frame_done |=> !frame_done
    ) else begin
        $error("frame_done stayed high for more than one cycle");
        failures++;
    end

    // done only right after the last beat of the frame
    a_done_after_last: assert property (
        @(posedge ClockA) disable iff (!rst_n)
        frame_done |-> ($past(beat_valid) && $past(beat_pixel) == LAST_PIXEL)
    ) else begin
        $error("frame_done without a preceding beat for the last pixel");
        failures++;
    end

    // reads only begin on a start pulse taken in idle
    a_read_needs_start: assert property (
        @(posedge ClockA) disable iff (!rst_n)
        $rose(rd_en) |-> ($past(scan_start) && $past(state) == scan_types_pkg::SCAN_IDLE)
    ) else begin
        $error("rd_en rose without a scan_start taken in SCAN_IDLE");
        failures++;
    end

endmodule

//--- tb/fb_checker.sv
// checking side of the framebuffer testbench
// shadow memory fed from host writes and a reference word function
// compare process for beat data, pixel order and frame length
`timescale 1ns/1ps
`include "fb_consts.svh"

module fb_checker (
    input  logic                       ClockA,
    input  logic                       rst_n,
    input  fb_types_pkg::fb_wr_req_t   wr,
    input  logic                       beat_valid,
    input  scan_types_pkg::scan_beat_t beat,
    input  logic                       scan_busy,
    input  logic                       frame_done,
    output int                         errors,
    output int                         frames
);
    localparam int PIX_W  = `FB_PIXEL_BITS;
    localparam int PIXELS = 1 << PIX_W;

    // expected RAM contents, lane first then pixel
    logic [`FB_DATA_BITS-1:0] shadow [`FB_LANES][PIXELS];
    // running state of the current frame
    int                          frame_beats;
    int                          next_pixel;
    int                          wr_lane;
    logic                        busy_q;
    logic [PIX_W-1:0]            exp_pixel;
    fb_types_pkg::fb_lane_word_t exp_word;

    // expected word for one pixel, lane k lands in byte k
    function automatic fb_types_pkg::fb_lane_word_t expected_word(input int pix);
        fb_types_pkg::fb_lane_word_t w;
        for (int k = 0; k < `FB_LANES; k++) begin
            w[k] = shadow[k][pix];
        end
        return w;
    endfunction

    initial begin
        errors           = 0;
        frames           = 0;
        frame_beats      = 0;
        next_pixel       = 0;
        busy_q           = 1'b0;
    end

    always @(posedge ClockA) begin
        if (!rst_n) begin
            // an aborted frame is forgotten
            frame_beats = 0;
            next_pixel  = 0;
            busy_q      = 1'b0;
        end else begin
            // lane index is subpanel * 4 + colour byte
            if (wr.we) begin
                wr_lane = wr.addr.subpanel * 4 + wr.addr.color;
                shadow[wr_lane][wr.addr.pixel] = wr.data;
            end
            if (beat_valid) begin
                exp_pixel = PIX_W'(next_pixel);
                exp_word  = expected_word(next_pixel);
                if (beat.pixel !== exp_pixel) begin
                    $display("Fail beat.pixel expected %h got %h", exp_pixel, beat.pixel);
                    errors++;
                end
                if (beat.word !== exp_word) begin
                    $display("Fail beat.word at pixel %0d expected %h got %h",
                             exp_pixel, exp_word, beat.word);
                    errors++;
                end
                frame_beats++;
                next_pixel = next_pixel + 1;
                if (frame_beats > PIXELS) begin
                    $display("more beats than pixels seen in one frame");
                    errors++;
                end
            end
            if (frame_done) begin
                if (frame_beats != PIXELS) begin
                    $display("frame ended after %0d beats instead of %0d", frame_beats, PIXELS);
                    errors++;
                end
                // busy drops on the same edge that raises done
                if (scan_busy || !busy_q) begin
                    $display("scan_busy did not fall together with frame_done");
                    errors++;
                end
                frames++;
                frame_beats      = 0;
                next_pixel       = 0;
            end else if (busy_q && !scan_busy) begin
                $display("scan_busy fell without a frame_done pulse");
                errors++;
            end
            busy_q = scan_busy;
        end
    end

endmodule

//--- tb/fb_tb.sv
// testbench top for the LED framebuffer
// clock, reset, LFSR stimulus and the six test cases
// watchdog and the closing summary
`timescale 1ns/1ps
`include "fb_consts.svh"

module fb_tb;
    localparam int PIXELS          = 1 << `FB_PIXEL_BITS;
    localparam int ADDR_W          = $bits(fb_types_pkg::fb_wr_addr_t);
    localparam int FILL_CYCLES     = PIXELS * `FB_LANES;
    // start to frame_done
    localparam int FRAME_CYCLES    = PIXELS + 3;
    localparam int WATCHDOG_CYCLES = (6 * FRAME_CYCLES + FILL_CYCLES) * 5 / 4;
    localparam logic [31:0] LFSR_SEED = 32'h431e_58f8;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic                       ClockA;
    logic                       rst_n;
    logic                       scan_start;
    logic                       beat_valid;
    logic                       scan_busy;
    logic                       frame_done;
    fb_types_pkg::fb_wr_req_t   wr;
    scan_types_pkg::scan_beat_t beat;
    int chk_errors, chk_frames;
    int tb_errors, tests_passed, tests_failed, start_errors, start_frames;
    logic [31:0] lfsr;

    framebuffer_top uut (
        .ClockA     (ClockA),
        .rst_n      (rst_n),
        .wr         (wr),
        .scan_start (scan_start),
        .beat_valid (beat_valid),
        .beat       (beat),
        .scan_busy  (scan_busy),
        .frame_done (frame_done)
    );

    fb_checker u_checker (
        .ClockA           (ClockA),
        .rst_n            (rst_n),
        .wr               (wr),
        .beat_valid       (beat_valid),
        .beat             (beat),
        .scan_busy        (scan_busy),
        .frame_done       (frame_done),
        .errors           (chk_errors),
        .frames           (chk_frames)
    );

    // only one scan_ctrl exists, so this lands on uut.u_scan
    bind scan_ctrl fb_asserts u_asserts (
        .ClockA     (ClockA),
        .rst_n      (rst_n),
        .scan_start (scan_start),
        .rd_en      (rd_en),
        .beat_valid (beat_valid),
        .beat_pixel (beat.pixel),
        .frame_done (frame_done),
        .state      (state)
    );

    initial begin
        ClockA = 1'b0;
        forever #5 ClockA = ~ClockA;
    end

    // galois step, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    // checker, test sequence and bound assertions together
    function automatic int error_count();
        return chk_errors + tb_errors + uut.u_scan.u_asserts.failures;
    endfunction

    // one LFSR step per bit
    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic send_write(input fb_types_pkg::fb_wr_req_t req);
        @(posedge ClockA);
        #1;
        wr = req;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge ClockA);
            #1;
            wr = '0;
        end
    endtask

    task automatic pulse_start();
        @(posedge ClockA);
        #1;
        scan_start = 1'b1;
        @(posedge ClockA);
        #1;
        scan_start = 1'b0;
    endtask

    task automatic wait_frame_done();
        bit seen;
        seen = 1'b0;
        for (int n = 0; n < FRAME_CYCLES + 16 && !seen; n++) begin
            @(posedge ClockA);
            seen = frame_done;
        end
        if (!seen) begin
            $display("timed out waiting for frame_done");
            tb_errors++;
        end
    endtask

    task automatic run_scan();
        pulse_start();
        wait_frame_done();
        idle_cycles(4);
    endtask

    task automatic check_low(input string name, input logic value);
        if (value !== 1'b0) begin
            $display("Fail %s expected %h got %h", name, 1'b0, value);
            tb_errors++;
        end
    endtask

    task automatic check_frames(input int n);
        if (chk_frames - start_frames != n) begin
            $display("expected %0d frame_done pulses but saw %0d", n, chk_frames - start_frames);
            tb_errors++;
        end
    endtask

    task automatic begin_test();
        start_errors = error_count();
        start_frames = chk_frames;
    endtask

    task automatic end_test(input int num, input string name);
        int delta;
        delta = error_count() - start_errors;
        if (delta == 0) begin
            $display("test %0d %s: passed", num, name);
            tests_passed++;
        end else begin
            $display("test %0d %s: failed with %0d errors", num, name, delta);
            tests_failed++;
        end
    endtask

    // run limit from fill length and frame count
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ClockA);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        logic [31:0]              r;
        logic [31:0]              d;
        logic [ADDR_W-1:0]        addr_bits;
        logic [2:0]               lane;
        fb_types_pkg::fb_wr_req_t req;
        lfsr         = LFSR_SEED;
        tb_errors    = 0;
        tests_passed = 0;
        tests_failed = 0;
        rst_n        = 1'b0;
        wr           = '0;
        scan_start   = 1'b0;
        repeat (4) @(posedge ClockA);
        #1;
        rst_n = 1'b1;
        idle_cycles(2);

        // every byte of every lane, address order
        begin_test();
        for (int a = 0; a < FILL_CYCLES; a++) begin
            take_bits(8, d);
            addr_bits = ADDR_W'(a);
            req.we    = 1'b1;
            req.addr  = addr_bits;
            req.data  = d[7:0];
            send_write(req);
        end
        idle_cycles(4);
        run_scan();
        check_frames(1);
        end_test(1, "full fill and scan");

        // framing is watched by the checker, busy rise checked here
        begin_test();
        pulse_start();
        if (scan_busy !== 1'b1) begin
            $display("scan_busy did not rise after scan_start");
            tb_errors++;
        end
        wait_frame_done();
        idle_cycles(4);
        check_frames(1);
        end_test(2, "scan framing");

        // one byte per write, lanes taken in turn
        begin_test();
        for (int i = 0; i < 32; i++) begin
            take_bits(`FB_PIXEL_BITS, r);
            take_bits(8, d);
            lane                  = 3'(i);
            req.we                = 1'b1;
            req.addr.subpanel     = lane[2];
            req.addr.color        = lane[1:0];
            req.addr.pixel        = r[`FB_PIXEL_BITS-1:0];
            req.data              = d[7:0];
            send_write(req);
        end
        idle_cycles(4);
        run_scan();
        check_frames(1);
        end_test(3, "single lane overwrite");

        // random requests with we low must not land
        begin_test();
        for (int i = 0; i < 64; i++) begin
            take_bits(ADDR_W, r);
            take_bits(8, d);
            req.we   = 1'b0;
            req.addr = r[ADDR_W-1:0];
            req.data = d[7:0];
            send_write(req);
        end
        idle_cycles(4);
        run_scan();
        check_frames(1);
        end_test(4, "write strobe gating");

        // second start lands while busy
        begin_test();
        pulse_start();
        idle_cycles(100);
        pulse_start();
        wait_frame_done();
        idle_cycles(10);
        check_frames(1);
        check_low("scan_busy", scan_busy);
        end_test(5, "start while busy");

        // reset part way through a frame, RAM keeps its data
        begin_test();
        pulse_start();
        idle_cycles(300);
        rst_n = 1'b0;
        #1;
        check_low("beat_valid", beat_valid);
        check_low("scan_busy", scan_busy);
        check_low("frame_done", frame_done);
        repeat (4) @(posedge ClockA);
        #1;
        rst_n = 1'b1;
        idle_cycles(2);
        check_low("beat_valid", beat_valid);
        check_low("scan_busy", scan_busy);
        check_low("frame_done", frame_done);
        run_scan();
        check_frames(1);
        end_test(6, "reset mid scan");

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed,
                 error_count());
        if (error_count() == 0 && tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- framebuffer.f
+incdir+include
logic/fb_types_pkg.sv
logic/scan_types_pkg.sv
logic/mem_lane.sv
logic/multimem.sv
logic/scan_ctrl.sv
logic/framebuffer_top.sv
tb/fb_asserts.sv
tb/fb_checker.sv
tb/fb_tb.sv
